/* verilog.f */
rtl/lsu_pkg.sv
rtl/lsu_l1d.sv
rtl/lsu_stbuf.sv
rtl/lsu_pipe.sv
rtl/lsu.sv
rtl/lsu_top.sv
dv/tb_lsu_top.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_l1d.sv
  - rtl/lsu_stbuf.sv
  - rtl/lsu_pipe.sv
  - rtl/lsu.sv
  - rtl/lsu_top.sv
  - target: test
    files:
      - dv/tb_lsu_top.sv

/* dv/tb_lsu_top.sv */
module tb_lsu_top
   import lsu_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int L1D_WORDS   = 64;
   localparam int STBUF_DEPTH = 4;
   localparam int NUM_CYCLES  = 600;

   typedef struct packed {
      mem_issue_t issue;
      int         taken_cycle;
   } exp_op_t;

   logic       i_clk;
   logic       i_rst_n;
   logic       i_ldq_replay_valid;
   mem_issue_t i_ldq_replay;
   logic       i_stq_replay_valid;
   mem_issue_t i_stq_replay;
   logic       i_drain_en;
   logic       o_ldq_conflict;
   logic       o_stq_conflict;
   phy_wr_t    o_ex3_phy_wr;
   done_t      o_ex3_done;

   integer     seed;
   int         cycle_cnt;
   int         n_loads;
   int         n_replays;
   exp_op_t    exp_q [$];
   data_t      cache_m [L1D_WORDS];
   addr_t      sb_word [$];
   data_t      sb_data [$];

   lsu_top lsu_top_inst (
      .i_clk              (i_clk),
      .i_rst_n            (i_rst_n),
      .i_ldq_replay_valid (i_ldq_replay_valid),
      .i_ldq_replay       (i_ldq_replay),
      .i_stq_replay_valid (i_stq_replay_valid),
      .i_stq_replay       (i_stq_replay),
      .i_drain_en         (i_drain_en),
      .o_ldq_conflict     (o_ldq_conflict),
      .o_stq_conflict     (o_stq_conflict),
      .o_ex3_phy_wr       (o_ex3_phy_wr),
      .o_ex3_done         (o_ex3_done)
   );

   always #20 i_clk = ~i_clk;

   task automatic report_error(string what);
      $display("Error at %0t: %s", $time, what);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %0h got %0h", $time, name, expected, actual);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   // One-hot group id, position of the set bit
   function automatic int lowest_set(grp_id_t g);
      for (int i = 0; i < GRP_W; i++) begin
         if (g[i]) return i;
      end
      return GRP_W;
   endfunction

   function automatic logic older_than(mem_issue_t a, mem_issue_t b);
      if (a.cmt_id == b.cmt_id) return lowest_set(a.grp_id) < lowest_set(b.grp_id);
      if (a.cmt_id[CMT_ID_W-1] == b.cmt_id[CMT_ID_W-1]) begin
         return a.cmt_id[CMT_ID_W-2:0] < b.cmt_id[CMT_ID_W-2:0];
      end
      return a.cmt_id[CMT_ID_W-2:0] > b.cmt_id[CMT_ID_W-2:0];
   endfunction

   // ==================================================
   // Model of one rising edge and output check
   // ==================================================

   task automatic step_cycle();
      logic    ld_take;
      logic    have;
      logic    is_load;
      logic    rp;
      exp_op_t op;
      addr_t   word;
      data_t   ld_val;
      ld_take = i_ldq_replay_valid &
                (~i_stq_replay_valid | older_than(i_ldq_replay, i_stq_replay));
      check_value("o_ldq_conflict", !ld_take, o_ldq_conflict);
      check_value("o_stq_conflict", ld_take, o_stq_conflict);
      if (i_ldq_replay_valid | i_stq_replay_valid) begin
         op.issue       = ld_take ? i_ldq_replay : i_stq_replay;
         op.taken_cycle = cycle_cnt;
         exp_q.push_back(op);
      end
      // Operation leaving ex2 at this edge
      have    = (exp_q.size() != 0) && (exp_q[0].taken_cycle == cycle_cnt - 3);
      is_load = 1'b0;
      rp      = 1'b0;
      ld_val  = '0;
      if (have) begin
         op      = exp_q.pop_front();
         word    = (op.issue.addr >> 2) % L1D_WORDS;
         is_load = (op.issue.op == MEM_LOAD);
         if (is_load) begin
            ld_val = cache_m[word];
            foreach (sb_word[i]) begin
               if (sb_word[i] == word) ld_val = sb_data[i];
            end
         end else begin
            rp = (sb_word.size() == STBUF_DEPTH);
         end
      end
      if (i_drain_en && sb_word.size() != 0) begin
         cache_m[sb_word[0]] = sb_data[0];
         void'(sb_word.pop_front());
         void'(sb_data.pop_front());
      end
      if (have && !is_load && !rp) begin
         sb_word.push_back(word);
         sb_data.push_back(op.issue.st_data);
      end
      check_value("o_ex3_done.valid", have, o_ex3_done.valid);
      check_value("o_ex3_phy_wr.valid", have & is_load, o_ex3_phy_wr.valid);
      if (have) begin
         check_value("o_ex3_done.cmt_id", op.issue.cmt_id, o_ex3_done.cmt_id);
         check_value("o_ex3_done.grp_id", op.issue.grp_id, o_ex3_done.grp_id);
         check_value("o_ex3_done.replay", rp, o_ex3_done.replay);
         if (rp) n_replays++;
         if (is_load) begin
            n_loads++;
            check_value("o_ex3_phy_wr.rd", op.issue.rd, o_ex3_phy_wr.rd);
            check_value("o_ex3_phy_wr.data", ld_val, o_ex3_phy_wr.data);
         end
      end
   endtask

   function automatic mem_issue_t random_issue(mem_op_e op);
      mem_issue_t m;
      m.op      = op;
      m.cmt_id  = cmt_id_t'($random(seed));
      m.grp_id  = $random(seed) & 1 ? 2'b10 : 2'b01;
      m.addr    = addr_t'($random(seed)) & 32'h3f;
      m.st_data = data_t'($random(seed));
      m.rd      = preg_t'($random(seed));
      return m;
   endfunction

   task automatic drive_random(logic hold_drain);
      logic [31:0] r;
      r = $random(seed);
      i_ldq_replay_valid = r[1:0] != 2'b00;
      i_stq_replay_valid = r[3:2] != 2'b00;
      i_ldq_replay       = random_issue(MEM_LOAD);
      i_stq_replay       = random_issue(MEM_STORE);
      // Equal commit ids now and then, so group ids decide
      if (r[5:4] == 2'b00) i_stq_replay.cmt_id = i_ldq_replay.cmt_id;
      i_drain_en = hold_drain ? 1'b0 : r[6];
   endtask

   initial begin
      int wait_cnt;
      seed               = 32'hc346_a64f;
      i_clk              = 1'b0;
      i_rst_n            = 1'b0;
      i_ldq_replay_valid = 1'b0;
      i_ldq_replay       = '0;
      i_stq_replay_valid = 1'b0;
      i_stq_replay       = '0;
      i_drain_en         = 1'b0;
      cycle_cnt          = 0;
      n_loads            = 0;
      n_replays          = 0;
      foreach (cache_m[i]) cache_m[i] = '0;
      repeat (8) @(posedge i_clk);
      @(negedge i_clk);
      check_value("o_ex3_done.valid", 1'b0, o_ex3_done.valid);
      check_value("o_ex3_phy_wr.valid", 1'b0, o_ex3_phy_wr.valid);
      check_value("o_ldq_conflict", 1'b1, o_ldq_conflict);
      check_value("o_stq_conflict", 1'b0, o_stq_conflict);
      i_rst_n = 1'b1;
      // Drain held off in the middle to fill the store buffer
      for (int c = 0; c < NUM_CYCLES; c++) begin
         @(negedge i_clk);
         cycle_cnt++;
         step_cycle();
         drive_random(c >= 200 && c < 260);
      end
      i_ldq_replay_valid = 1'b0;
      i_stq_replay_valid = 1'b0;
      i_drain_en         = 1'b1;
      wait_cnt           = 0;
      while (exp_q.size() != 0) begin
         @(negedge i_clk);
         cycle_cnt++;
         wait_cnt++;
         if (wait_cnt > 20) report_error("operations never showed up on o_ex3_done");
         step_cycle();
      end
      if (n_replays != 0 && n_loads != 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         report_error("the run saw no store replay or no load result");
      end
   end

endmodule

/* rtl/lsu_top.sv */
module lsu_top
   import lsu_pkg::*;
#(
   parameter int L1D_WORDS   = 64,
   parameter int STBUF_DEPTH = 4
) (
   input  logic       i_clk,
   input  logic       i_rst_n,

   input  logic       i_ldq_replay_valid,
   input  mem_issue_t i_ldq_replay,
   input  logic       i_stq_replay_valid,
   input  mem_issue_t i_stq_replay,
   input  logic       i_drain_en,

   output logic       o_ldq_conflict,
   output logic       o_stq_conflict,
   output phy_wr_t    o_ex3_phy_wr,
   output done_t      o_ex3_done
);

   // Lane to cache read path
   logic         w_ex1_rd_valid;
   addr_t        w_ex1_rd_word;
   data_t        w_ex2_rd_data;

   // Lane to store buffer
   addr_t        w_ex2_fwd_word;
   logic         w_ex2_fwd_hit;
   data_t        w_ex2_fwd_data;
   logic         w_ex2_st_valid;
   stbuf_entry_t w_ex2_st_entry;
   logic         w_stbuf_full;

   // Store buffer drain into the cache
   logic         w_drain_valid;
   stbuf_entry_t w_drain_entry;

   lsu #(
      .L1D_WORDS (L1D_WORDS)
   ) u_lsu (
      .i_clk              (i_clk),
      .i_rst_n            (i_rst_n),
      .i_ldq_replay_valid (i_ldq_replay_valid),
      .i_ldq_replay       (i_ldq_replay),
      .i_stq_replay_valid (i_stq_replay_valid),
      .i_stq_replay       (i_stq_replay),
      .o_ldq_conflict     (o_ldq_conflict),
      .o_stq_conflict     (o_stq_conflict),
      .o_ex1_rd_valid     (w_ex1_rd_valid),
      .o_ex1_rd_word      (w_ex1_rd_word),
      .i_ex2_rd_data      (w_ex2_rd_data),
      .o_ex2_fwd_word     (w_ex2_fwd_word),
      .i_ex2_fwd_hit      (w_ex2_fwd_hit),
      .i_ex2_fwd_data     (w_ex2_fwd_data),
      .o_ex2_st_valid     (w_ex2_st_valid),
      .o_ex2_st_entry     (w_ex2_st_entry),
      .i_ex2_stbuf_full   (w_stbuf_full),
      .o_ex3_phy_wr       (o_ex3_phy_wr),
      .o_ex3_done         (o_ex3_done)
   );

   lsu_stbuf #(
      .STBUF_DEPTH (STBUF_DEPTH)
   ) u_stbuf (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_enq_valid   (w_ex2_st_valid),
      .i_enq_entry   (w_ex2_st_entry),
      .o_full        (w_stbuf_full),
      .i_fwd_word    (w_ex2_fwd_word),
      .o_fwd_hit     (w_ex2_fwd_hit),
      .o_fwd_data    (w_ex2_fwd_data),
      .i_drain_en    (i_drain_en),
      .o_drain_valid (w_drain_valid),
      .o_drain_entry (w_drain_entry)
   );

   lsu_l1d #(
      .L1D_WORDS (L1D_WORDS)
   ) u_l1d (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rd_valid (w_ex1_rd_valid),
      .i_rd_word  (w_ex1_rd_word),
      .o_rd_data  (w_ex2_rd_data),
      .i_wr_valid (w_drain_valid),
      .i_wr_entry (w_drain_entry)
   );

endmodule

/* rtl/lsu.sv */
module lsu
   import lsu_pkg::*;
#(
   parameter int L1D_WORDS = 64
) (
   input  logic         i_clk,
   input  logic         i_rst_n,

   // Replay sources
   input  logic         i_ldq_replay_valid,
   input  mem_issue_t   i_ldq_replay,
   input  logic         i_stq_replay_valid,
   input  mem_issue_t   i_stq_replay,
   output logic         o_ldq_conflict,
   output logic         o_stq_conflict,

   // Cache read and store buffer access
   output logic         o_ex1_rd_valid,
   output addr_t        o_ex1_rd_word,
   input  data_t        i_ex2_rd_data,
   output addr_t        o_ex2_fwd_word,
   input  logic         i_ex2_fwd_hit,
   input  data_t        i_ex2_fwd_data,
   output logic         o_ex2_st_valid,
   output stbuf_entry_t o_ex2_st_entry,
   input  logic         i_ex2_stbuf_full,

   output phy_wr_t      o_ex3_phy_wr,
   output done_t        o_ex3_done
);

   logic       w_same_wrap;
   logic       w_same_id;
   logic       w_ld_older;
   logic       w_ld_taken;
   logic       w_ex0_valid;
   mem_issue_t w_ex0_issue;

   // ==================================================
   // Age check between LDQ and STQ heads
   // ==================================================

   assign w_same_wrap = i_ldq_replay.cmt_id[CMT_ID_W-1] == i_stq_replay.cmt_id[CMT_ID_W-1];
   assign w_same_id   = i_ldq_replay.cmt_id == i_stq_replay.cmt_id;

   // Group ids are one-hot, so lower set bit means smaller value
   always_comb begin
      if (w_same_id) begin
         w_ld_older = i_ldq_replay.grp_id < i_stq_replay.grp_id;
      end else if (w_same_wrap) begin
         w_ld_older = i_ldq_replay.cmt_id[CMT_ID_W-2:0] < i_stq_replay.cmt_id[CMT_ID_W-2:0];
      end else begin
         w_ld_older = i_ldq_replay.cmt_id[CMT_ID_W-2:0] > i_stq_replay.cmt_id[CMT_ID_W-2:0];
      end
   end

   assign w_ld_taken = i_ldq_replay_valid & (~i_stq_replay_valid | w_ld_older);

   assign o_ldq_conflict = ~w_ld_taken;
   assign o_stq_conflict =  w_ld_taken;

   assign w_ex0_valid = i_ldq_replay_valid | i_stq_replay_valid;
   assign w_ex0_issue = w_ld_taken ? i_ldq_replay : i_stq_replay;

   lsu_pipe #(
      .L1D_WORDS (L1D_WORDS)
   ) u_lsu_pipe (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_ex0_valid      (w_ex0_valid),
      .i_ex0_issue      (w_ex0_issue),
      .o_ex1_rd_valid   (o_ex1_rd_valid),
      .o_ex1_rd_word    (o_ex1_rd_word),
      .i_ex2_rd_data    (i_ex2_rd_data),
      .o_ex2_fwd_word   (o_ex2_fwd_word),
      .i_ex2_fwd_hit    (i_ex2_fwd_hit),
      .i_ex2_fwd_data   (i_ex2_fwd_data),
      .o_ex2_st_valid   (o_ex2_st_valid),
      .o_ex2_st_entry   (o_ex2_st_entry),
      .i_ex2_stbuf_full (i_ex2_stbuf_full),
      .o_ex3_phy_wr     (o_ex3_phy_wr),
      .o_ex3_done       (o_ex3_done)
   );

endmodule

/* rtl/lsu_pipe.sv */
module lsu_pipe
   import lsu_pkg::*;
#(
   parameter int L1D_WORDS = 64
) (
   input  logic         i_clk,
   input  logic         i_rst_n,

   // Chosen operation, captured into ex0
   input  logic         i_ex0_valid,
   input  mem_issue_t   i_ex0_issue,

   // ex1 cache read
   output logic         o_ex1_rd_valid,
   output addr_t        o_ex1_rd_word,

   // ex2 cache data, forwarding and store enqueue
   input  data_t        i_ex2_rd_data,
   output addr_t        o_ex2_fwd_word,
   input  logic         i_ex2_fwd_hit,
   input  data_t        i_ex2_fwd_data,
   output logic         o_ex2_st_valid,
   output stbuf_entry_t o_ex2_st_entry,
   input  logic         i_ex2_stbuf_full,

   // ex3 results
   output phy_wr_t      o_ex3_phy_wr,
   output done_t        o_ex3_done
);

   localparam addr_t WORDS = addr_t'(L1D_WORDS);

   logic       r_ex0_valid;
   mem_issue_t r_ex0_issue;

   logic       r_ex1_valid;
   mem_issue_t r_ex1_issue;
   addr_t      w_ex1_word;

   logic       r_ex2_valid;
   mem_issue_t r_ex2_issue;
   addr_t      r_ex2_word;
   logic       w_ex2_is_store;
   data_t      w_ex2_ld_data;
   logic       w_ex2_replay;

   logic       r_ex3_valid;
   mem_issue_t r_ex3_issue;
   data_t      r_ex3_data;
   logic       r_ex3_replay;

   // ==================================================
   // Stage valids
   // ==================================================

   // Every stage moves each cycle, nothing stalls
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         r_ex0_valid <= 1'b0;
         r_ex1_valid <= 1'b0;
         r_ex2_valid <= 1'b0;
         r_ex3_valid <= 1'b0;
      end else begin
         r_ex0_valid <= i_ex0_valid;
         r_ex1_valid <= r_ex0_valid;
         r_ex2_valid <= r_ex1_valid;
         r_ex3_valid <= r_ex2_valid;
      end
   end

   // ==================================================
   // Stage payload
   // ==================================================

   always_ff @(posedge i_clk) begin
      r_ex0_issue  <= i_ex0_issue;
      r_ex1_issue  <= r_ex0_issue;
      r_ex2_issue  <= r_ex1_issue;
      r_ex2_word   <= w_ex1_word;
      r_ex3_issue  <= r_ex2_issue;
      r_ex3_data   <= w_ex2_ld_data;
      r_ex3_replay <= w_ex2_replay;
   end

   // ==================================================
   // ex1: word address and cache read
   // ==================================================

   // Byte address to word index inside the array
   assign w_ex1_word = (r_ex1_issue.addr >> 2) % WORDS;

   assign o_ex1_rd_valid = r_ex1_valid & (r_ex1_issue.op == MEM_LOAD);
   assign o_ex1_rd_word  = w_ex1_word;

   // ==================================================
   // ex2: forwarding and store enqueue
   // ==================================================

   assign o_ex2_fwd_word = r_ex2_word;

   // Buffered store data is younger than the cache copy
   assign w_ex2_ld_data = i_ex2_fwd_hit ? i_ex2_fwd_data : i_ex2_rd_data;

   assign w_ex2_is_store = r_ex2_valid & (r_ex2_issue.op == MEM_STORE);

   assign o_ex2_st_valid           = w_ex2_is_store & ~i_ex2_stbuf_full;
   assign o_ex2_st_entry.word_addr = r_ex2_word;
   assign o_ex2_st_entry.data      = r_ex2_issue.st_data;

   // Full buffer, the STQ must offer this store again
   assign w_ex2_replay = w_ex2_is_store & i_ex2_stbuf_full;

   // ==================================================
   // ex3: result write and completion
   // ==================================================

   assign o_ex3_phy_wr.valid = r_ex3_valid & (r_ex3_issue.op == MEM_LOAD);
   assign o_ex3_phy_wr.rd    = r_ex3_issue.rd;
   assign o_ex3_phy_wr.data  = r_ex3_data;

   assign o_ex3_done.valid  = r_ex3_valid;
   assign o_ex3_done.cmt_id = r_ex3_issue.cmt_id;
   assign o_ex3_done.grp_id = r_ex3_issue.grp_id;
   assign o_ex3_done.replay = r_ex3_replay;

endmodule

/* rtl/lsu_stbuf.sv */
module lsu_stbuf
   import lsu_pkg::*;
#(
   parameter int STBUF_DEPTH = 4
) (
   input  logic         i_clk,
   input  logic         i_rst_n,

   input  logic         i_enq_valid,
   input  stbuf_entry_t i_enq_entry,
   output logic         o_full,

   input  addr_t        i_fwd_word,
   output logic         o_fwd_hit,
   output data_t        o_fwd_data,

   input  logic         i_drain_en,
   output logic         o_drain_valid,
   output stbuf_entry_t o_drain_entry
);

   localparam int PTR_W = (STBUF_DEPTH > 1) ? $clog2(STBUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(STBUF_DEPTH + 1);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   stbuf_entry_t r_entries [STBUF_DEPTH];
   ptr_t         r_head;
   ptr_t         r_tail;
   cnt_t         r_count;
   logic         w_enq;
   logic         w_drain;

   // Pointer step with wrap for any depth
   function automatic ptr_t ptr_add(ptr_t ptr, int unsigned off);
      int unsigned sum;
      sum = ptr + off;
      if (sum >= STBUF_DEPTH) begin
         sum = sum - STBUF_DEPTH;
      end
      return ptr_t'(sum);
   endfunction

   assign o_full  = (r_count == cnt_t'(STBUF_DEPTH));
   assign w_enq   = i_enq_valid & ~o_full;
   assign w_drain = i_drain_en & (r_count != '0);

   assign o_drain_valid = w_drain;
   assign o_drain_entry = r_entries[r_head];

   // Walk oldest to youngest so the last hit is the youngest store
   always_comb begin
      o_fwd_hit  = 1'b0;
      o_fwd_data = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if ((cnt_t'(i) < r_count) &&
             (r_entries[ptr_add(r_head, i)].word_addr == i_fwd_word)) begin
            o_fwd_hit  = 1'b1;
            o_fwd_data = r_entries[ptr_add(r_head, i)].data;
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         r_head  <= '0;
         r_tail  <= '0;
         r_count <= '0;
      end else begin
         if (w_enq) r_tail <= ptr_add(r_tail, 1);
         if (w_drain) r_head <= ptr_add(r_head, 1);
         case ({w_enq, w_drain})
            2'b10:   r_count <= r_count + 1'b1;
            2'b01:   r_count <= r_count - 1'b1;
            default: r_count <= r_count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (w_enq) begin
         r_entries[r_tail] <= i_enq_entry;
      end
   end

endmodule

/* rtl/lsu_l1d.sv */
module lsu_l1d
   import lsu_pkg::*;
#(
   parameter int L1D_WORDS = 64
) (
   input  logic         i_clk,
   input  logic         i_rst_n,

   input  logic         i_rd_valid,
   input  addr_t        i_rd_word,
   output data_t        o_rd_data,

   input  logic         i_wr_valid,
   input  stbuf_entry_t i_wr_entry
);

   localparam int IDX_W = (L1D_WORDS > 1) ? $clog2(L1D_WORDS) : 1;

   data_t            r_mem [L1D_WORDS];
   logic [IDX_W-1:0] w_rd_idx;
   logic [IDX_W-1:0] w_wr_idx;

   // Upper word address bits are not part of the index
   assign w_rd_idx = i_rd_word[IDX_W-1:0];
   assign w_wr_idx = i_wr_entry.word_addr[IDX_W-1:0];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < L1D_WORDS; i++) begin
            r_mem[i] <= '0;
         end
      end else if (i_wr_valid) begin
         r_mem[w_wr_idx] <= i_wr_entry.data;
      end
   end

   // Write-first, a drain at the same edge is seen by the read
   always_ff @(posedge i_clk) begin
      if (i_rd_valid) begin
         if (i_wr_valid && (w_wr_idx == w_rd_idx)) begin
            o_rd_data <= i_wr_entry.data;
         end else begin
            o_rd_data <= r_mem[w_rd_idx];
         end
      end
   end

endmodule

/* rtl/lsu_pkg.sv */
package lsu_pkg;

   // ==================================================
   // Widths
   // ==================================================

   // Top bit of a commit id is the wrap bit
   parameter int CMT_ID_W = 5;
   parameter int GRP_W    = 2;
   parameter int ADDR_W   = 32;
   parameter int DATA_W   = 32;
   parameter int PREG_W   = 6;

   typedef logic [CMT_ID_W-1:0] cmt_id_t;
   typedef logic [GRP_W-1:0]    grp_id_t;
   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [PREG_W-1:0]   preg_t;

   // ==================================================
   // Memory operation types
   // ==================================================

   typedef enum logic {
      MEM_LOAD  = 1'b0,
      MEM_STORE = 1'b1
   } mem_op_e;

   // One operation as offered by the LDQ or STQ
   typedef struct packed {
      mem_op_e op;
      cmt_id_t cmt_id;
      grp_id_t grp_id;
      addr_t   addr;
      data_t   st_data;
      preg_t   rd;
   } mem_issue_t;

   // Load result toward the register file
   typedef struct packed {
      logic  valid;
      preg_t rd;
      data_t data;
   } phy_wr_t;

   // Completion report, replay set means offer it again
   typedef struct packed {
      logic    valid;
      cmt_id_t cmt_id;
      grp_id_t grp_id;
      logic    replay;
   } done_t;

   // Store buffer entry, word_addr is the reduced word index
   typedef struct packed {
      addr_t word_addr;
      data_t data;
   } stbuf_entry_t;

endpackage
